//--- design/solver_cfg.svh
`ifndef SOLVER_CFG_SVH
`define SOLVER_CFG_SVH

// Limb addressing and limb width
`define SOLVER_LIMB_INDEX_BITS 6
`define SOLVER_LIMB_BITS 27

// Entries per limb memory
`define SOLVER_LIMB_DEPTH (1 << `SOLVER_LIMB_INDEX_BITS)

// Full product of two limbs
`define SOLVER_PRODUCT_BITS (2 * `SOLVER_LIMB_BITS)

// Product plus headroom for carries summed over every limb position
`define SOLVER_ACC_BITS (`SOLVER_PRODUCT_BITS + `SOLVER_LIMB_INDEX_BITS)

`endif

//--- design/solver_pkg.sv
`default_nettype none

`include "solver_cfg.svh"

package solver_pkg;

    typedef logic [`SOLVER_LIMB_BITS-1:0] limb_t;
    typedef logic [`SOLVER_LIMB_INDEX_BITS-1:0] index_t;
    typedef logic [`SOLVER_PRODUCT_BITS-1:0] product_t;
    typedef logic signed [`SOLVER_ACC_BITS-1:0] acc_t;

    // R-stage treatment of a z limb
    typedef enum logic [1:0] {
        neg_keep   = 2'd0,
        neg_invert = 2'd1,
        neg_negate = 2'd2
    } neg_sel_e;

    // Operand register a z limb is steered into
    typedef enum logic [1:0] {
        reg_to_a    = 2'd0,
        reg_to_b    = 2'd1,
        reg_no_load = 2'd2
    } reg_sel_e;

    typedef enum logic [2:0] {
        re_none      = 3'd0,
        re_twice     = 3'd1,
        re_twice_neg = 3'd2,
        re_once      = 3'd3,
        re_once_neg  = 3'd4
    } re_partial_e;

    typedef enum logic [1:0] {
        im_none      = 2'd0,
        im_twice     = 2'd1,
        im_twice_neg = 2'd2
    } im_partial_e;

    typedef enum logic [1:0] {
        acc_add         = 2'd0,
        acc_carry_add_c = 2'd1,
        acc_set         = 2'd2,
        acc_hold        = 2'd3
    } acc_sel_e;

    typedef struct packed {
        logic  cre_wr_en;
        logic  cim_wr_en;
        limb_t cre_limb;
        limb_t cim_limb;
    } load_t;

    typedef struct packed {
        index_t   c_ind;
        index_t   zre_ind;
        index_t   zim_ind;
        neg_sel_e zre_neg;
        neg_sel_e zim_neg;
        reg_sel_e zre_reg;
        reg_sel_e zim_reg;
    } read_cmd_t;

    typedef struct packed {
        re_partial_e zre_partial;
        im_partial_e zim_partial;
        acc_sel_e    zre_acc;
        acc_sel_e    zim_acc;
    } exec_cmd_t;

    typedef struct packed {
        logic   clear_lsd;
        logic   zre_wr_en;
        logic   zim_wr_en;
        index_t zre_wr_ind;
        index_t zim_wr_ind;
    } write_cmd_t;

    typedef struct packed {
        read_cmd_t  read_cmd;
        exec_cmd_t  exec_cmd;
        write_cmd_t write_cmd;
    } command_t;

    typedef struct packed {
        limb_t re;
        limb_t im;
    } limb_pair_t;

    typedef struct packed {
        logic   wr_en;
        index_t ind;
        limb_t  limb;
    } writeback_t;

endpackage

`default_nettype wire

//--- design/limb_store.sv
`default_nettype none

`include "solver_cfg.svh"

module limb_store (
    input  logic                   clock,
    input  solver_pkg::load_t      load,
    input  solver_pkg::index_t     c_ind,
    input  solver_pkg::index_t     zre_ind,
    input  solver_pkg::index_t     zim_ind,
    input  solver_pkg::writeback_t zre_wb,
    input  solver_pkg::writeback_t zim_wb,
    output solver_pkg::limb_pair_t c_pair,
    output solver_pkg::limb_t      zre_raw,
    output solver_pkg::limb_t      zim_raw
);
    import solver_pkg::*;

    // One memory per component of c and z
    limb_t cre_mem [`SOLVER_LIMB_DEPTH];
    limb_t cim_mem [`SOLVER_LIMB_DEPTH];
    limb_t zre_mem [`SOLVER_LIMB_DEPTH];
    limb_t zim_mem [`SOLVER_LIMB_DEPTH];

    // c limbs come straight from the registered load word
    always_ff @(posedge clock) begin
        if (load.cre_wr_en) begin
            cre_mem[c_ind] <= load.cre_limb;
        end
        if (load.cim_wr_en) begin
            cim_mem[c_ind] <= load.cim_limb;
        end
    end

    // z limbs are written back from the W stage
    always_ff @(posedge clock) begin
        if (zre_wb.wr_en) begin
            zre_mem[zre_wb.ind] <= zre_wb.limb;
        end
        if (zim_wb.wr_en) begin
            zim_mem[zim_wb.ind] <= zim_wb.limb;
        end
    end

    // Asynchronous reads at the R-stage indices
    assign c_pair.re = cre_mem[c_ind];
    assign c_pair.im = cim_mem[c_ind];

    // A read in the same cycle as a write sees the old limb
    assign zre_raw = zre_mem[zre_ind];
    assign zim_raw = zim_mem[zim_ind];

endmodule

`default_nettype wire

//--- design/multiply_stage.sv
`default_nettype none

module multiply_stage (
    input  logic                   clock,
    input  logic                   reset,
    input  solver_pkg::read_cmd_t  read_cmd,
    input  solver_pkg::exec_cmd_t  exec_cmd,
    input  solver_pkg::write_cmd_t write_cmd,
    input  solver_pkg::limb_pair_t c_pair,
    input  solver_pkg::limb_t      zre_raw,
    input  solver_pkg::limb_t      zim_raw,
    output solver_pkg::product_t   m1_product,
    output solver_pkg::product_t   m2_product,
    output solver_pkg::limb_pair_t x_c_pair,
    output solver_pkg::exec_cmd_t  x_exec_cmd,
    output solver_pkg::write_cmd_t x_write_cmd
);
    import solver_pkg::*;

    // Negated z limbs in the R stage
    limb_t      r_zre;
    limb_t      r_zim;

    // M-stage state
    limb_t      reg_a;
    limb_t      reg_b;
    limb_t      m_zre;
    limb_t      m_zim;
    limb_pair_t m_c_pair;
    exec_cmd_t  m_exec_cmd;
    write_cmd_t m_write_cmd;

    function automatic limb_t apply_neg(input limb_t limb, input neg_sel_e sel);
        case (sel)
            neg_invert: return ~limb;
            neg_negate: return ~limb + limb_t'(1);
            default:    return limb;
        endcase
    endfunction

    assign r_zre = apply_neg(zre_raw, read_cmd.zre_neg);
    assign r_zim = apply_neg(zim_raw, read_cmd.zim_neg);

    // R to M, zre wins when both limbs pick the same register
    always_ff @(posedge clock) begin
        if (reset) begin
            reg_a       <= '0;
            reg_b       <= '0;
            m_zre       <= '0;
            m_zim       <= '0;
            m_c_pair    <= '0;
            m_exec_cmd  <= '0;
            m_write_cmd <= '0;
        end else begin
            if (read_cmd.zre_reg == reg_to_a) begin
                reg_a <= r_zre;
            end else if (read_cmd.zim_reg == reg_to_a) begin
                reg_a <= r_zim;
            end

            if (read_cmd.zre_reg == reg_to_b) begin
                reg_b <= r_zre;
            end else if (read_cmd.zim_reg == reg_to_b) begin
                reg_b <= r_zim;
            end

            m_zre       <= r_zre;
            m_zim       <= r_zim;
            m_c_pair    <= c_pair;
            m_exec_cmd  <= exec_cmd;
            m_write_cmd <= write_cmd;
        end
    end

    // M to X, both unsigned multipliers
    always_ff @(posedge clock) begin
        if (reset) begin
            m1_product  <= '0;
            m2_product  <= '0;
            x_c_pair    <= '0;
            x_exec_cmd  <= '0;
            x_write_cmd <= '0;
        end else begin
            m1_product  <= product_t'(reg_a) * product_t'(reg_b);
            m2_product  <= product_t'(m_zre) * product_t'(m_zim);
            x_c_pair    <= m_c_pair;
            x_exec_cmd  <= m_exec_cmd;
            x_write_cmd <= m_write_cmd;
        end
    end

endmodule

`default_nettype wire

//--- design/accumulate_stage.sv
`default_nettype none

`include "solver_cfg.svh"

module accumulate_stage (
    input  logic                   clock,
    input  logic                   reset,
    input  solver_pkg::product_t   m1_product,
    input  solver_pkg::product_t   m2_product,
    input  solver_pkg::limb_pair_t c_pair,
    input  solver_pkg::exec_cmd_t  exec_cmd,
    input  solver_pkg::write_cmd_t write_cmd,
    output solver_pkg::limb_t      zre_limb,
    output solver_pkg::limb_t      zim_limb,
    output solver_pkg::write_cmd_t w_write_cmd
);
    import solver_pkg::*;

    acc_t zre_acc;
    acc_t zim_acc;
    acc_t zre_partial;
    acc_t zim_partial;
    acc_t zre_next;
    acc_t zim_next;

    // Zero-extend, optionally double, then negate modulo the accumulator width
    function automatic acc_t scale(input product_t product, input logic doubled,
                                   input logic negated);
        acc_t value;
        value = acc_t'(product);
        if (doubled) begin
            value = value << 1;
        end
        if (negated) begin
            value = -value;
        end
        return value;
    endfunction

    function automatic acc_t acc_update(input acc_sel_e sel, input acc_t partial,
                                        input acc_t acc, input limb_t c);
        case (sel)
            acc_add:         return partial + acc;
            // Keep only the signed carry out of the finished limb
            acc_carry_add_c: return partial + (acc >>> `SOLVER_LIMB_BITS) + acc_t'(c);
            acc_set:         return partial;
            default:         return acc;
        endcase
    endfunction

    always_comb begin
        case (exec_cmd.zre_partial)
            re_twice:     zre_partial = scale(m1_product, 1'b1, 1'b0);
            re_twice_neg: zre_partial = scale(m1_product, 1'b1, 1'b1);
            re_once:      zre_partial = scale(m1_product, 1'b0, 1'b0);
            re_once_neg:  zre_partial = scale(m1_product, 1'b0, 1'b1);
            default:      zre_partial = '0;
        endcase

        // Imaginary side only ever sees the 2*zre*zim term
        case (exec_cmd.zim_partial)
            im_twice:     zim_partial = scale(m2_product, 1'b1, 1'b0);
            im_twice_neg: zim_partial = scale(m2_product, 1'b1, 1'b1);
            default:      zim_partial = '0;
        endcase
    end

    assign zre_next = acc_update(exec_cmd.zre_acc, zre_partial, zre_acc, c_pair.re);
    assign zim_next = acc_update(exec_cmd.zim_acc, zim_partial, zim_acc, c_pair.im);

    always_ff @(posedge clock) begin
        if (reset) begin
            zre_acc <= '0;
            zim_acc <= '0;
        end else begin
            zre_acc <= zre_next;
            zim_acc <= zim_next;
        end
    end

    // Low limb of the updated value goes to the W stage
    assign zre_limb    = zre_next[`SOLVER_LIMB_BITS-1:0];
    assign zim_limb    = zim_next[`SOLVER_LIMB_BITS-1:0];
    assign w_write_cmd = write_cmd;

endmodule

`default_nettype wire

//--- design/writeback_stage.sv
`default_nettype none

module writeback_stage (
    input  logic                   clock,
    input  logic                   reset,
    input  solver_pkg::limb_t      zre_limb,
    input  solver_pkg::limb_t      zim_limb,
    input  solver_pkg::write_cmd_t write_cmd,
    output solver_pkg::writeback_t zre_wb,
    output solver_pkg::writeback_t zim_wb,
    output solver_pkg::index_t     zre_lsd,
    output solver_pkg::index_t     zim_lsd
);
    import solver_pkg::*;

    logic clear_lsd;

    // Highest index so far that received a nonzero limb
    function automatic index_t lsd_next(input index_t lsd, input writeback_t wb);
        if (wb.wr_en && wb.limb != '0 && wb.ind > lsd) begin
            return wb.ind;
        end
        return lsd;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            zre_wb    <= '0;
            zim_wb    <= '0;
            clear_lsd <= 1'b0;
        end else begin
            zre_wb.wr_en <= write_cmd.zre_wr_en;
            zre_wb.ind   <= write_cmd.zre_wr_ind;
            zre_wb.limb  <= zre_limb;
            zim_wb.wr_en <= write_cmd.zim_wr_en;
            zim_wb.ind   <= write_cmd.zim_wr_ind;
            zim_wb.limb  <= zim_limb;
            clear_lsd    <= write_cmd.clear_lsd;
        end
    end

    // Updated on the same edge as the z memory write
    always_ff @(posedge clock) begin
        if (reset || clear_lsd) begin
            zre_lsd <= '0;
            zim_lsd <= '0;
        end else begin
            zre_lsd <= lsd_next(zre_lsd, zre_wb);
            zim_lsd <= lsd_next(zim_lsd, zim_wb);
        end
    end

endmodule

`default_nettype wire

//--- design/solver_top.sv
`default_nettype none

module solver_top (
    input  logic                   clock,
    input  logic                   reset,
    input  solver_pkg::load_t      load,
    input  solver_pkg::command_t   command,
    output solver_pkg::writeback_t zre_wb,
    output solver_pkg::writeback_t zim_wb,
    output solver_pkg::index_t     zre_lsd,
    output solver_pkg::index_t     zim_lsd
);
    import solver_pkg::*;

    // C to R boundary
    load_t      load_q;
    command_t   command_q;

    limb_pair_t c_pair;
    limb_t      zre_raw;
    limb_t      zim_raw;
    product_t   m1_product;
    product_t   m2_product;
    limb_pair_t x_c_pair;
    exec_cmd_t  x_exec_cmd;
    write_cmd_t x_write_cmd;
    limb_t      zre_limb;
    limb_t      zim_limb;
    write_cmd_t w_write_cmd;

    always_ff @(posedge clock) begin
        if (reset) begin
            load_q    <= '0;
            command_q <= '0;
        end else begin
            load_q    <= load;
            command_q <= command;
        end
    end

    limb_store limb_store_i (
        .clock   (clock),
        .load    (load_q),
        .c_ind   (command_q.read_cmd.c_ind),
        .zre_ind (command_q.read_cmd.zre_ind),
        .zim_ind (command_q.read_cmd.zim_ind),
        .zre_wb  (zre_wb),
        .zim_wb  (zim_wb),
        .c_pair  (c_pair),
        .zre_raw (zre_raw),
        .zim_raw (zim_raw)
    );

    multiply_stage multiply_stage_i (
        .clock       (clock),
        .reset       (reset),
        .read_cmd    (command_q.read_cmd),
        .exec_cmd    (command_q.exec_cmd),
        .write_cmd   (command_q.write_cmd),
        .c_pair      (c_pair),
        .zre_raw     (zre_raw),
        .zim_raw     (zim_raw),
        .m1_product  (m1_product),
        .m2_product  (m2_product),
        .x_c_pair    (x_c_pair),
        .x_exec_cmd  (x_exec_cmd),
        .x_write_cmd (x_write_cmd)
    );

    accumulate_stage accumulate_stage_i (
        .clock       (clock),
        .reset       (reset),
        .m1_product  (m1_product),
        .m2_product  (m2_product),
        .c_pair      (x_c_pair),
        .exec_cmd    (x_exec_cmd),
        .write_cmd   (x_write_cmd),
        .zre_limb    (zre_limb),
        .zim_limb    (zim_limb),
        .w_write_cmd (w_write_cmd)
    );

    // Writeback feeds both the z memories and the outputs
    writeback_stage writeback_stage_i (
        .clock     (clock),
        .reset     (reset),
        .zre_limb  (zre_limb),
        .zim_limb  (zim_limb),
        .write_cmd (w_write_cmd),
        .zre_wb    (zre_wb),
        .zim_wb    (zim_wb),
        .zre_lsd   (zre_lsd),
        .zim_lsd   (zim_lsd)
    );

endmodule

`default_nettype wire

//--- bench/solver_chk.sv
`default_nettype none

module solver_chk (
    input wire logic                   clock,
    input wire logic                   reset,
    input wire solver_pkg::writeback_t zre_wb,
    input wire solver_pkg::writeback_t zim_wb,
    input wire solver_pkg::index_t     zre_lsd,
    input wire solver_pkg::index_t     zim_lsd,
    input wire logic                   clear_lsd
);
    import solver_pkg::*;

    int failures = 0;

    // Writeback registers come out of reset with no write pending
    wr_en_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> (!zre_wb.wr_en && !zim_wb.wr_en))
        else begin
            $error("writeback enable set on the cycle after reset");
            failures++;
        end

    // lsd never drops except to zero after a registered clear
    zre_lsd_rises: assert property (@(posedge clock) disable iff (reset)
        (zre_lsd >= $past(zre_lsd)) || (zre_lsd == '0 && $past(clear_lsd)))
        else begin
            $error("zre lsd dropped without a clear");
            failures++;
        end

    zim_lsd_rises: assert property (@(posedge clock) disable iff (reset)
        (zim_lsd >= $past(zim_lsd)) || (zim_lsd == '0 && $past(clear_lsd)))
        else begin
            $error("zim lsd dropped without a clear");
            failures++;
        end

endmodule

bind solver_top solver_chk solver_chk_i (
    .clock     (clock),
    .reset     (reset),
    .zre_wb    (zre_wb),
    .zim_wb    (zim_wb),
    .zre_lsd   (zre_lsd),
    .zim_lsd   (zim_lsd),
    .clear_lsd (writeback_stage_i.clear_lsd)
);

`default_nettype wire

//--- bench/solver_tb.sv
`default_nettype none

`include "solver_cfg.svh"

module solver_tb;
    import solver_pkg::*;

    localparam int MAX_ROWS = 128;

    logic       clock;
    logic       reset;
    load_t      load;
    command_t   command;
    writeback_t zre_wb;
    writeback_t zim_wb;
    index_t     zre_lsd;
    index_t     zim_lsd;

    // Stimulus and expected values, one row per cycle
    load_t      row_load [MAX_ROWS];
    command_t   row_cmd [MAX_ROWS];
    writeback_t exp_zre_wb [MAX_ROWS];
    writeback_t exp_zim_wb [MAX_ROWS];
    index_t     exp_zre_lsd [MAX_ROWS];
    index_t     exp_zim_lsd [MAX_ROWS];
    int         n_rows = 0;
    int         lsd_checked = 0;

    // Reference model state
    limb_t      m_cre [64];
    limb_t      m_cim [64];
    limb_t      m_zre [64];
    limb_t      m_zim [64];
    limb_t      m_a = '0;
    limb_t      m_b = '0;
    acc_t       m_acc_re = '0;
    acc_t       m_acc_im = '0;
    index_t     m_lsd_re = '0;
    index_t     m_lsd_im = '0;

    logic [15:0] lfsr = 16'd58;

    solver_top solver_top_i (
        .clock   (clock),
        .reset   (reset),
        .load    (load),
        .command (command),
        .zre_wb  (zre_wb),
        .zim_wb  (zim_wb),
        .zre_lsd (zre_lsd),
        .zim_lsd (zim_lsd)
    );

    always #50 clock = ~clock;

    // Any failed assertion in the bound checker ends the run
    always @(solver_top_i.solver_chk_i.failures) begin
        if (solver_top_i.solver_chk_i.failures != 0) begin
            $display("A bound assertion on the top level failed");
            $display("Checks failed");
            $fatal(1);
        end
    end

    // Galois LFSR, one step per limb bit
    function automatic limb_t random_limb();
        limb_t value;
        for (int i = 0; i < `SOLVER_LIMB_BITS; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            value[i] = lfsr[0];
        end
        return value;
    endfunction

    function automatic command_t idle_cmd();
        command_t c;
        c = '0;
        c.read_cmd.zre_reg = reg_no_load;
        c.read_cmd.zim_reg = reg_no_load;
        c.exec_cmd.zre_acc = acc_hold;
        c.exec_cmd.zim_acc = acc_hold;
        return c;
    endfunction

    function automatic limb_t negate_limb(input limb_t v, input neg_sel_e sel);
        if (sel == neg_invert) begin
            return ~v;
        end
        if (sel == neg_negate) begin
            return -v;
        end
        return v;
    endfunction

    function automatic acc_t next_acc(input acc_sel_e sel, input acc_t partial,
                                      input acc_t acc, input limb_t c);
        if (sel == acc_add) begin
            return partial + acc;
        end
        if (sel == acc_carry_add_c) begin
            return partial + (acc >>> `SOLVER_LIMB_BITS) + acc_t'(c);
        end
        if (sel == acc_set) begin
            return partial;
        end
        return acc;
    endfunction

    function automatic index_t next_lsd(input index_t lsd, input writeback_t wb);
        if (wb.wr_en && wb.limb != '0 && wb.ind > lsd) begin
            return wb.ind;
        end
        return lsd;
    endfunction

    // Runs one command through the model and appends it to the table
    task automatic add_row(input load_t l, input command_t c);
        limb_pair_t cp;
        limb_t      rzre;
        limb_t      rzim;
        product_t   p1;
        product_t   p2;
        acc_t       pre;
        acc_t       pim;
        writeback_t wre;
        writeback_t wim;
        cp.re = m_cre[c.read_cmd.c_ind];
        cp.im = m_cim[c.read_cmd.c_ind];
        if (l.cre_wr_en) begin
            m_cre[c.read_cmd.c_ind] = l.cre_limb;
        end
        if (l.cim_wr_en) begin
            m_cim[c.read_cmd.c_ind] = l.cim_limb;
        end
        rzre = negate_limb(m_zre[c.read_cmd.zre_ind], c.read_cmd.zre_neg);
        rzim = negate_limb(m_zim[c.read_cmd.zim_ind], c.read_cmd.zim_neg);
        if (c.read_cmd.zre_reg == reg_to_a) begin
            m_a = rzre;
        end else if (c.read_cmd.zim_reg == reg_to_a) begin
            m_a = rzim;
        end
        if (c.read_cmd.zre_reg == reg_to_b) begin
            m_b = rzre;
        end else if (c.read_cmd.zim_reg == reg_to_b) begin
            m_b = rzim;
        end
        p1 = product_t'(m_a) * product_t'(m_b);
        p2 = product_t'(rzre) * product_t'(rzim);
        case (c.exec_cmd.zre_partial)
            re_once:      pre = acc_t'(p1);
            re_once_neg:  pre = -acc_t'(p1);
            re_twice:     pre = acc_t'(p1) * 2;
            re_twice_neg: pre = -(acc_t'(p1) * 2);
            default:      pre = '0;
        endcase
        case (c.exec_cmd.zim_partial)
            im_twice:     pim = acc_t'(p2) * 2;
            im_twice_neg: pim = -(acc_t'(p2) * 2);
            default:      pim = '0;
        endcase
        m_acc_re = next_acc(c.exec_cmd.zre_acc, pre, m_acc_re, cp.re);
        m_acc_im = next_acc(c.exec_cmd.zim_acc, pim, m_acc_im, cp.im);
        wre = '{wr_en: c.write_cmd.zre_wr_en, ind: c.write_cmd.zre_wr_ind,
                limb: m_acc_re[`SOLVER_LIMB_BITS-1:0]};
        wim = '{wr_en: c.write_cmd.zim_wr_en, ind: c.write_cmd.zim_wr_ind,
                limb: m_acc_im[`SOLVER_LIMB_BITS-1:0]};
        if (wre.wr_en) begin
            m_zre[wre.ind] = wre.limb;
        end
        if (wim.wr_en) begin
            m_zim[wim.ind] = wim.limb;
        end
        if (c.write_cmd.clear_lsd) begin
            m_lsd_re = '0;
            m_lsd_im = '0;
        end else begin
            m_lsd_re = next_lsd(m_lsd_re, wre);
            m_lsd_im = next_lsd(m_lsd_im, wim);
        end
        row_load[n_rows] = l;
        row_cmd[n_rows] = c;
        exp_zre_wb[n_rows] = wre;
        exp_zim_wb[n_rows] = wim;
        exp_zre_lsd[n_rows] = m_lsd_re;
        exp_zim_lsd[n_rows] = m_lsd_im;
        n_rows++;
    endtask

    // Lets a z write land before a later row reads it
    task automatic add_gap();
        for (int i = 0; i < 4; i++) begin
            add_row('0, idle_cmd());
        end
    endtask

    task automatic check_wb(input writeback_t got, input writeback_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic check_index(input index_t got, input index_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic build_table();
        load_t    l;
        command_t c;
        index_t   targets [3];
        targets = '{6'd5, 6'd9, 6'd2};
        // Load c limbs and copy them into z through carry_add_c
        for (int t = 0; t < 3; t++) begin
            l = '0;
            l.cre_wr_en = 1'b1;
            l.cim_wr_en = 1'b1;
            l.cre_limb = random_limb();
            l.cim_limb = random_limb();
            c = idle_cmd();
            c.read_cmd.c_ind = index_t'(t + 1);
            add_row(l, c);
            c = idle_cmd();
            c.exec_cmd.zre_acc = acc_set;
            c.exec_cmd.zim_acc = acc_set;
            add_row('0, c);
            c = idle_cmd();
            c.read_cmd.c_ind = index_t'(t + 1);
            c.exec_cmd.zre_acc = acc_carry_add_c;
            c.exec_cmd.zim_acc = acc_carry_add_c;
            c.write_cmd.zre_wr_en = 1'b1;
            c.write_cmd.zim_wr_en = 1'b1;
            c.write_cmd.zre_wr_ind = targets[t];
            c.write_cmd.zim_wr_ind = targets[t];
            add_row('0, c);
        end
        // Zero limb at a higher index leaves lsd alone
        c = idle_cmd();
        c.exec_cmd.zre_acc = acc_set;
        c.exec_cmd.zim_acc = acc_set;
        c.write_cmd.zre_wr_en = 1'b1;
        c.write_cmd.zim_wr_en = 1'b1;
        c.write_cmd.zre_wr_ind = 6'd12;
        c.write_cmd.zim_wr_ind = 6'd12;
        add_row('0, c);
        add_gap();
        // Negation modes into A, partner limb into B
        for (int n = 0; n < 3; n++) begin
            for (int s = 0; s < 2; s++) begin
                c = idle_cmd();
                c.read_cmd.zre_ind = 6'd5;
                c.read_cmd.zim_ind = 6'd9;
                c.read_cmd.zre_neg = neg_sel_e'(n);
                c.read_cmd.zre_reg = reg_to_a;
                c.read_cmd.zim_reg = reg_to_b;
                c.exec_cmd.zre_partial = (s == 0) ? re_once : re_once_neg;
                c.exec_cmd.zre_acc = acc_set;
                // Imaginary path doubling
                c.exec_cmd.zim_partial = (s == 0) ? im_twice : im_twice_neg;
                c.exec_cmd.zim_acc = acc_set;
                add_row('0, c);
            end
        end
        // Multi-limb run with carries
        for (int k = 0; k < 4; k++) begin
            c = idle_cmd();
            c.read_cmd.c_ind = 6'd1;
            c.read_cmd.zre_ind = 6'd5;
            c.read_cmd.zim_ind = 6'd9;
            c.exec_cmd.zre_partial = (k == 1) ? re_twice_neg : ((k == 3) ? re_none : re_once);
            c.exec_cmd.zim_partial = (k == 3) ? im_none : ((k == 1) ? im_twice_neg : im_twice);
            c.exec_cmd.zre_acc = acc_sel_e'(k == 0 ? acc_set : (k == 1 ? acc_add :
                                 (k == 2 ? acc_carry_add_c : acc_hold)));
            c.exec_cmd.zim_acc = c.exec_cmd.zre_acc;
            c.write_cmd.zre_wr_en = 1'b1;
            c.write_cmd.zim_wr_en = 1'b1;
            c.write_cmd.zre_wr_ind = index_t'(20 + k);
            c.write_cmd.zim_wr_ind = index_t'(20 + k);
            add_row('0, c);
        end
        add_gap();
        c = idle_cmd();
        c.write_cmd.clear_lsd = 1'b1;
        add_row('0, c);
        add_gap();
    endtask

    // One clock: check results of earlier rows, then drive row j
    task automatic step_cycle(input int j);
        @(posedge clock);
        #10;
        if (j >= 4 && j - 4 < n_rows) begin
            check_wb(zre_wb, exp_zre_wb[j-4], "zre_wb");
            check_wb(zim_wb, exp_zim_wb[j-4], "zim_wb");
        end
        if (j >= 5 && j - 5 < n_rows) begin
            check_index(zre_lsd, exp_zre_lsd[j-5], "zre_lsd");
            check_index(zim_lsd, exp_zim_lsd[j-5], "zim_lsd");
            lsd_checked++;
        end
        load = (j < n_rows) ? row_load[j] : '0;
        command = (j < n_rows) ? row_cmd[j] : idle_cmd();
    endtask

    initial begin
        int cycles;
        int j;
        clock = 1'b0;
        reset = 1'b1;
        load = '0;
        command = idle_cmd();
        build_table();
        for (int i = 0; i < 3; i++) begin
            @(posedge clock);
        end
        #10;
        reset = 1'b0;
        cycles = 0;
        while ((zre_wb.wr_en !== 1'b0 || zim_wb.wr_en !== 1'b0) && cycles < 10) begin
            @(posedge clock);
            cycles++;
        end
        if (zre_wb.wr_en !== 1'b0 || zim_wb.wr_en !== 1'b0) begin
            $display("Timed out waiting for the writeback outputs to leave reset");
            $display("Checks failed");
            $fatal(1);
        end
        check_wb(zre_wb, '0, "zre_wb after reset");
        check_wb(zim_wb, '0, "zim_wb after reset");
        check_index(zre_lsd, '0, "zre_lsd after reset");
        check_index(zim_lsd, '0, "zim_lsd after reset");
        for (j = 0; j < n_rows; j++) begin
            step_cycle(j);
        end
        cycles = 0;
        while (lsd_checked < n_rows && cycles < 20) begin
            step_cycle(j);
            j++;
            cycles++;
        end
        if (lsd_checked < n_rows) begin
            $display("Timed out waiting for the last rows to leave the pipeline");
            $display("Checks failed");
            $fatal(1);
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- solver_top.f
+incdir+design
design/solver_pkg.sv
design/limb_store.sv
design/multiply_stage.sv
design/accumulate_stage.sv
design/writeback_stage.sv
design/solver_top.sv
bench/solver_chk.sv
bench/solver_tb.sv
